// File: memory_upload.f
logic/msx_pkg.sv
logic/upload_tracker.sv
logic/config_sequencer.sv
logic/fill_pattern_gen.sv
logic/slot_layout_table.sv
logic/memory_upload.sv
bench/memory_upload_sva.sv
bench/memory_upload_tb.sv

// File: bench/memory_upload_tb.sv
`timescale 1ns/1ps
`default_nettype none

module memory_upload_tb;

   // Two ROM copies of 16 KB and two pattern loads of 64 KB
   localparam longint FILL_BYTES  = 2 * 16384 + 2 * 65536;
   localparam longint WATCHDOG_NS = (FILL_BYTES * 4 + 6 * 2000) * 20;

   logic clk = 1'b0;
   logic reset, ioctl_download, reload, ddr3_ready, sdram_ready, stall_en;
   logic reset_rq, ddr3_rd, ddr3_request, ram_ce, use_fdc;
   logic                 [15:0] ioctl_index;
   logic                  [3:0] slot_expander_en;
   msx_pkg::ram_addr_t    ioctl_addr, ram_addr;
   msx_pkg::ddr3_addr_t   ddr3_addr;
   msx_pkg::byte_t        ddr3_dout, ram_din, ram_size;
   msx_pkg::msx_typ_t     msx_typ;
   msx_pkg::mapper_typ_t  slot_mapper  [msx_pkg::SLOT_ENTRIES];
   msx_pkg::device_typ_t  slot_device  [msx_pkg::SLOT_ENTRIES];
   msx_pkg::ref_ram_t     slot_ref_ram [msx_pkg::SLOT_ENTRIES];
   logic            [1:0] slot_offset  [msx_pkg::SLOT_ENTRIES];
   msx_pkg::ram_addr_t    lookup_addr  [msx_pkg::LOOKUP_ENTRIES];
   msx_pkg::lookup_size_t lookup_size  [msx_pkg::LOOKUP_ENTRIES];
   logic                  lookup_ro    [msx_pkg::LOOKUP_ENTRIES];
   msx_pkg::byte_t        ddr   [32768];
   msx_pkg::byte_t        sdram [65536];   // Captured writes
   integer seed = 32'h3f22;
   int errors = 0;
   int tests = 0;

   memory_upload memory_upload_i (.*);

   always #10 clk = ~clk;

   always @(posedge clk) begin
      if (ddr3_rd && ddr3_ready)
         ddr3_dout <= ddr[ddr3_addr[14:0]];   // Held until the next read
      if (ram_ce)
         sdram[ram_addr[15:0]] <= ram_din;
      ddr3_ready  <= !stall_en || ($random(seed) & 3) != 0;
      sdram_ready <= !stall_en || ($random(seed) & 3) != 0;
   end

   task automatic mismatch(input string what, input logic [31:0] got, exp);
      errors++;
      $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
   endtask

   task automatic check_byte(input string what, input msx_pkg::byte_t got, exp);
      if (got !== exp)
         mismatch(what, got, exp);
   endtask

   task automatic check_addr(input string what, input msx_pkg::ram_addr_t got, exp);
      if (got !== exp)
         mismatch(what, got, exp);
   endtask

   task automatic check_size(input string what, input msx_pkg::lookup_size_t got, exp);
      if (got !== exp)
         mismatch(what, got, exp);
   endtask

   task automatic check_mapper(input string what, input msx_pkg::mapper_typ_t got, exp);
      if (got !== exp)
         mismatch(what, got, exp);
   endtask

   function automatic msx_pkg::byte_t pattern_byte(input msx_pkg::pattern_t pat,
                                                   input logic [8:0] p);
      case (pat)
         3'd3: return p[8] ? (p[1] ? 8'hFF : 8'h00) : (p[1] ? 8'h00 : 8'hFF);
         3'd4: return p[8] ? (p[0] ? 8'h00 : 8'hFF) : (p[0] ? 8'hFF : 8'h00);
         3'd5: return p[7] ? 8'hFF : 8'h00;
         default: return 8'hFF;
      endcase
   endfunction

   // Fields are bytes 3 to 11 of the record
   task automatic put_record(input int at, input logic [71:0] fields);
      ddr[at]     = "M";
      ddr[at + 1] = "S";
      ddr[at + 2] = "X";
      for (int i = 0; i < 9; i++)
         ddr[at + 3 + i] = fields[71 - 8*i -: 8];
   endtask

   task automatic clear_capture();
      for (int i = 0; i < 65536; i++)
         sdram[i] = 'x;
   endtask

   task automatic run_load(input logic by_reload, input msx_pkg::ram_addr_t size);
      @(posedge clk);
      reload         <= by_reload;
      ioctl_download <= !by_reload;
      ioctl_index    <= msx_pkg::UPLOAD_INDEX;
      ioctl_addr     <= size;
      @(posedge clk);
      reload         <= 1'b0;
      ioctl_download <= 1'b0;
      @(posedge clk);
      while (!reset_rq)
         @(posedge clk);
      while (reset_rq)             // Falls when the loader is done
         @(posedge clk);
   endtask

   task automatic test_done(input string name, input int start);
      tests++;
      $display("%s: %0d errors", name, errors - start);
   endtask

   task automatic check_rom_image();
      for (int k = 0; k < 16384; k++)
         check_byte("rom byte", sdram[k], ddr[16 + k]);
      check_addr("lookup 0 addr", lookup_addr[0], '0);
      check_size("lookup 0 size", lookup_size[0], 16'd1);
      check_byte("lookup 0 ro", 8'(lookup_ro[0]), 8'd1);
      for (int b = 0; b < 4; b++) begin
         check_mapper("rom mapper", slot_mapper[36 + b], msx_pkg::MAPPER_ASCII16);
         check_byte("rom device", slot_device[36 + b], msx_pkg::DEVICE_NONE);
         check_byte("rom ref", 8'(slot_ref_ram[36 + b]), 8'd0);
         check_byte("rom offset", 8'(slot_offset[36 + b]), 8'(b));
      end
   endtask

   task automatic check_patterns();
      check_addr("lookup 1 addr", lookup_addr[1], 27'd16384);
      check_addr("lookup 2 addr", lookup_addr[2], 27'd49152);
      check_size("lookup 1 size", lookup_size[1], 16'd2);
      check_byte("ram_size", ram_size, 8'd2);
      for (int i = 0; i < 3; i++) begin
         check_byte("lookup ro", 8'(lookup_ro[i]), 8'd0);
         check_byte("region ref", 8'(slot_ref_ram[4 + 4*i]), 8'(i));
      end
      for (int k = 0; k < 16384; k++) begin
         check_byte("pattern 3 byte", sdram[k], pattern_byte(3'd3, 9'(k)));
         check_byte("pattern 5 byte", sdram[49152 + k], pattern_byte(3'd5, 9'(k)));
      end
      for (int k = 0; k < 32768; k++)
         check_byte("pattern 4 byte", sdram[16384 + k], pattern_byte(3'd4, 9'(k)));
   endtask

   task automatic config_only_test();
      int start;
      start = errors;
      check_byte("idle strobes", {4'd0, reset_rq, ddr3_rd, ddr3_request, ram_ce}, 8'd0);
      put_record(0, {8'h50, 8'h2A, 16'd0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00});
      run_load(1'b0, 27'd16);
      for (int i = 0; i < msx_pkg::SLOT_ENTRIES; i++) begin
         check_mapper("cleared mapper", slot_mapper[i], msx_pkg::MAPPER_UNUSED);
         check_byte("cleared device", slot_device[i], msx_pkg::DEVICE_NONE);
      end
      check_byte("slot_expander_en", 8'(slot_expander_en), 8'h0A);
      check_byte("msx_typ", 8'(msx_typ), 8'(msx_pkg::MSX2P));
      test_done("config_only", start);
   endtask

   task automatic rom_copy_test();
      int start;
      start = errors;
      put_record(0, {8'h39, msx_pkg::ROM_ROM, 16'd1, msx_pkg::DEVICE_NONE,
                     msx_pkg::MAPPER_ASCII16, 8'hAA, 8'hE4, 8'h00});
      clear_capture();
      run_load(1'b0, 27'd16400);
      check_rom_image();
      test_done("rom_copy", start);
   endtask

   task automatic slot_mode_test();
      int start;
      start = errors;
      put_record(0, {8'h35, msx_pkg::ROM_NONE, 16'd0, msx_pkg::DEVICE_NONE,
                     msx_pkg::MAPPER_ASCII8, 8'h02, 8'h02, 8'h00});
      // Block 1 mirrors block 0 while block 0 is rewritten
      put_record(16, {8'h35, msx_pkg::ROM_NONE, 16'd0, msx_pkg::DEVICE_FDC,
                      msx_pkg::MAPPER_KONAMI, 8'h36, 8'h31, 8'h00});
      run_load(1'b0, 27'd32);
      check_mapper("block 0 mapper", slot_mapper[20], msx_pkg::MAPPER_KONAMI);
      check_byte("block 0 offset", 8'(slot_offset[20]), 8'd1);
      check_mapper("mirror mapper", slot_mapper[21], msx_pkg::MAPPER_ASCII8);
      check_byte("mirror device", slot_device[21], msx_pkg::DEVICE_NONE);
      check_byte("mirror offset", 8'(slot_offset[21]), 8'd2);
      check_mapper("mode 3 mapper", slot_mapper[22], msx_pkg::MAPPER_UNUSED);
      check_byte("mode 3 device", slot_device[22], msx_pkg::DEVICE_FDC);
      check_byte("mode 3 offset", 8'(slot_offset[22]), 8'd3);
      check_mapper("mode 0 mapper", slot_mapper[23], msx_pkg::MAPPER_UNUSED);
      check_byte("use_fdc", 8'(use_fdc), 8'd1);
      test_done("slot_mode", start);
   endtask

   task automatic bad_header_test();
      int start;
      start = errors;
      put_record(0, {8'h39, msx_pkg::ROM_ROM, 16'd1, msx_pkg::DEVICE_NONE,
                     msx_pkg::MAPPER_ASCII16, 8'hAA, 8'hE4, 8'h00});
      put_record(16400, {8'h33, msx_pkg::ROM_NONE, 16'd0, msx_pkg::DEVICE_NONE,
                         msx_pkg::MAPPER_KONAMI, 8'hAA, 8'h00, 8'h00});
      ddr[16402] = "Y";
      put_record(16416, {8'h33, msx_pkg::ROM_NONE, 16'd0, msx_pkg::DEVICE_NONE,
                         msx_pkg::MAPPER_KONAMI, 8'hAA, 8'h00, 8'h00});
      clear_capture();
      stall_en <= 1'b1;
      run_load(1'b0, 27'd16432);
      stall_en <= 1'b0;
      check_rom_image();
      for (int b = 0; b < 4; b++)
         check_mapper("slot after bad record", slot_mapper[12 + b], msx_pkg::MAPPER_UNUSED);
      test_done("bad_header", start);
   endtask

   task automatic ram_pattern_test();
      int start;
      start = errors;
      // Block 0 of each slot points at its own region
      put_record(0, {8'h31, msx_pkg::ROM_RAM, 16'd1, msx_pkg::DEVICE_NONE,
                     msx_pkg::MAPPER_RAM, 8'h02, 8'h00, 8'h03});
      put_record(16, {8'h32, msx_pkg::ROM_RAM, 16'd2, msx_pkg::DEVICE_NONE,
                      msx_pkg::MAPPER_RAM, 8'h02, 8'h00, 8'h04});
      put_record(32, {8'h33, msx_pkg::ROM_RAM, 16'd1, msx_pkg::DEVICE_NONE,
                      msx_pkg::MAPPER_RAM, 8'h02, 8'h00, 8'h05});
      clear_capture();
      run_load(1'b0, 27'd48);
      check_patterns();
      test_done("ram_pattern", start);
   endtask

   task automatic reload_test();
      int start;
      start = errors;
      clear_capture();
      run_load(1'b1, '0);
      check_addr("lookup 0 addr", lookup_addr[0], '0);
      check_patterns();
      test_done("reload", start);
   endtask

   initial begin
      reset          = 1'b1;
      ioctl_download = 1'b0;
      ioctl_index    = '0;
      ioctl_addr     = '0;
      reload         = 1'b0;
      ddr3_dout      = '0;
      ddr3_ready     = 1'b1;
      sdram_ready    = 1'b1;
      stall_en       = 1'b0;
      for (int i = 0; i < 32768; i++)
         ddr[i] = msx_pkg::byte_t'(i ^ (i >> 8) ^ (i >> 13));
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      config_only_test();
      rom_copy_test();
      slot_mode_test();
      bad_header_test();
      ram_pattern_test();
      reload_test();
      errors += memory_upload_i.config_sequencer_i.sequencer_sva_i.fail_count;
      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the loader did not finish within %0d ns", WATCHDOG_NS);
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: bench/memory_upload_sva.sv
`timescale 1ns/1ps
`default_nettype none

module memory_upload_sva (
   input wire                  clk,
   input wire                  reset,
   input wire                  ram_ce,
   input wire                  ddr3_rd,
   input wire                  reset_rq,
   input wire msx_pkg::state_t state
);

   int fail_count = 0;

   ram_ce_single: assert property (@(posedge clk) disable iff (reset) ram_ce |=> !ram_ce)
      else begin
         fail_count++;
         $error("ram_ce high for two cycles");
      end

   strobes_after_reset: assert property (@(posedge clk) reset |=> !ram_ce && !ddr3_rd)
      else begin
         fail_count++;
         $error("strobe high after reset");
      end

   idle_quiet: assert property (@(posedge clk) disable iff (reset)
                                state == msx_pkg::STATE_IDLE |->
                                !reset_rq && !ddr3_rd && !ram_ce)
      else begin
         fail_count++;
         $error("loader busy in idle");
      end

endmodule

bind config_sequencer memory_upload_sva sequencer_sva_i (
   .clk      (clk),
   .reset    (reset),
   .ram_ce   (ram_ce),
   .ddr3_rd  (ddr3_rd),
   .reset_rq (reset_rq),
   .state    (state)
);

`default_nettype wire

// File: logic/memory_upload.sv
`timescale 1ns/1ps
`default_nettype none

module memory_upload (
   input  wire                       clk,
   input  wire                       reset,
   input  wire                       ioctl_download,
   input  wire                [15:0] ioctl_index,
   input  wire msx_pkg::ram_addr_t   ioctl_addr,
   input  wire                       reload,
   input  wire msx_pkg::byte_t       ddr3_dout,
   input  wire                       ddr3_ready,
   input  wire                       sdram_ready,
   output wire                       reset_rq,
   output wire msx_pkg::ddr3_addr_t  ddr3_addr,
   output wire                       ddr3_rd,
   output wire                       ddr3_request,
   output wire msx_pkg::ram_addr_t   ram_addr,
   output wire msx_pkg::byte_t       ram_din,
   output wire                       ram_ce,
   output wire msx_pkg::mapper_typ_t slot_mapper  [msx_pkg::SLOT_ENTRIES],
   output wire msx_pkg::device_typ_t slot_device  [msx_pkg::SLOT_ENTRIES],
   output wire msx_pkg::ref_ram_t    slot_ref_ram [msx_pkg::SLOT_ENTRIES],
   output wire                 [1:0] slot_offset  [msx_pkg::SLOT_ENTRIES],
   output wire msx_pkg::ram_addr_t   lookup_addr  [msx_pkg::LOOKUP_ENTRIES],
   output wire msx_pkg::lookup_size_t lookup_size [msx_pkg::LOOKUP_ENTRIES],
   output wire                       lookup_ro    [msx_pkg::LOOKUP_ENTRIES],
   output wire msx_pkg::byte_t       ram_size,
   output wire                       use_fdc,
   output wire                 [3:0] slot_expander_en,
   output wire msx_pkg::msx_typ_t    msx_typ
);

   wire                       load;
   wire msx_pkg::ram_addr_t   image_size;
   wire msx_pkg::pattern_t    pattern;
   wire msx_pkg::ram_addr_t   region_base;
   wire                       clear_en;
   wire msx_pkg::block_idx_t  clear_idx;
   wire                       store_en;
   wire msx_pkg::slot_sub_t   store_slot;
   wire msx_pkg::byte_t       mode;
   wire msx_pkg::byte_t       param;
   wire msx_pkg::mapper_typ_t mapper;
   wire msx_pkg::device_typ_t device;
   wire msx_pkg::data_id_t    data_id;
   wire msx_pkg::ref_ram_t    ref_ram;

   upload_tracker upload_tracker_i (
      .clk            (clk),
      .reset          (reset),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_addr     (ioctl_addr),
      .reload         (reload),
      .load           (load),
      .image_size     (image_size)
   );

   config_sequencer config_sequencer_i (
      .clk              (clk),
      .reset            (reset),
      .load             (load),
      .image_size       (image_size),
      .ddr3_dout        (ddr3_dout),
      .ddr3_ready       (ddr3_ready),
      .sdram_ready      (sdram_ready),
      .reset_rq         (reset_rq),
      .ddr3_addr        (ddr3_addr),
      .ddr3_rd          (ddr3_rd),
      .ddr3_request     (ddr3_request),
      .ram_addr         (ram_addr),
      .ram_ce           (ram_ce),
      .pattern          (pattern),
      .region_base      (region_base),
      .clear_en         (clear_en),
      .clear_idx        (clear_idx),
      .store_en         (store_en),
      .store_slot       (store_slot),
      .mode             (mode),
      .param            (param),
      .mapper           (mapper),
      .device           (device),
      .data_id          (data_id),
      .ref_ram          (ref_ram),
      .lookup_addr      (lookup_addr),
      .lookup_size      (lookup_size),
      .lookup_ro        (lookup_ro),
      .ram_size         (ram_size),
      .use_fdc          (use_fdc),
      .slot_expander_en (slot_expander_en),
      .msx_typ          (msx_typ)
   );

   fill_pattern_gen fill_pattern_gen_i (
      .pattern     (pattern),
      .ram_addr    (ram_addr),
      .region_base (region_base),
      .ddr3_dout   (ddr3_dout),
      .ram_din     (ram_din)
   );

   slot_layout_table slot_layout_table_i (
      .clk          (clk),
      .clear_en     (clear_en),
      .clear_idx    (clear_idx),
      .store_en     (store_en),
      .store_slot   (store_slot),
      .mode         (mode),
      .param        (param),
      .mapper       (mapper),
      .device       (device),
      .data_id      (data_id),
      .ref_ram      (ref_ram),
      .slot_mapper  (slot_mapper),
      .slot_device  (slot_device),
      .slot_ref_ram (slot_ref_ram),
      .slot_offset  (slot_offset)
   );

endmodule

`default_nettype wire

// File: logic/slot_layout_table.sv
`timescale 1ns/1ps
`default_nettype none

module slot_layout_table (
   input  wire                       clk,
   input  wire                       clear_en,
   input  wire msx_pkg::block_idx_t  clear_idx,
   input  wire                       store_en,
   input  wire msx_pkg::slot_sub_t   store_slot,
   input  wire msx_pkg::byte_t       mode,
   input  wire msx_pkg::byte_t       param,
   input  wire msx_pkg::mapper_typ_t mapper,
   input  wire msx_pkg::device_typ_t device,
   input  wire msx_pkg::data_id_t    data_id,
   input  wire msx_pkg::ref_ram_t    ref_ram,
   output msx_pkg::mapper_typ_t      slot_mapper  [msx_pkg::SLOT_ENTRIES],
   output msx_pkg::device_typ_t      slot_device  [msx_pkg::SLOT_ENTRIES],
   output msx_pkg::ref_ram_t         slot_ref_ram [msx_pkg::SLOT_ENTRIES],
   output logic                [1:0] slot_offset  [msx_pkg::SLOT_ENTRIES]
);

   always_ff @(posedge clk) begin
      if (clear_en) begin
         slot_mapper[clear_idx]  <= msx_pkg::MAPPER_UNUSED;
         slot_device[clear_idx]  <= msx_pkg::DEVICE_NONE;
         slot_ref_ram[clear_idx] <= '0;
         slot_offset[clear_idx]  <= '0;
      end
      if (store_en) begin
         // Nonblocking reads keep mirror sources at their pre-store values
         for (int b = 0; b < 4; b++) begin
            case (mode[2*b +: 2])
               2'd1: begin
                  slot_mapper[{store_slot, 2'(b)}]  <=
                     slot_mapper[{store_slot, param[2*b +: 2]}];
                  slot_device[{store_slot, 2'(b)}]  <=
                     slot_device[{store_slot, param[2*b +: 2]}];
                  slot_ref_ram[{store_slot, 2'(b)}] <=
                     slot_ref_ram[{store_slot, param[2*b +: 2]}];
                  slot_offset[{store_slot, 2'(b)}]  <=
                     slot_offset[{store_slot, param[2*b +: 2]}];
               end
               2'd2, 2'd3: begin
                  slot_mapper[{store_slot, 2'(b)}]  <= mode[2*b +: 2] == 2'd3 ?
                                                       msx_pkg::MAPPER_UNUSED : mapper;
                  slot_device[{store_slot, 2'(b)}]  <= device;
                  slot_ref_ram[{store_slot, 2'(b)}] <= data_id == msx_pkg::ROM_NONE ?
                                                       '0 : ref_ram;
                  slot_offset[{store_slot, 2'(b)}]  <= param[2*b +: 2];
               end
               default: ;                            // Block untouched
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/fill_pattern_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fill_pattern_gen (
   input  wire msx_pkg::pattern_t  pattern,
   input  wire msx_pkg::ram_addr_t ram_addr,
   input  wire msx_pkg::ram_addr_t region_base,
   input  wire msx_pkg::byte_t     ddr3_dout,
   output msx_pkg::byte_t          ram_din
);

   logic [8:0] pos;

   assign pos = 9'(ram_addr - region_base);   // Offset inside the region

   always_comb begin
      case (pattern)
         3'd0:    ram_din = ddr3_dout;
         3'd1:    ram_din = 8'hFF;
         3'd2:    ram_din = 8'h00;
         3'd3:    ram_din = {8{pos[8] ~^ pos[1]}};   // Pairs, phase flips at 256
         3'd4:    ram_din = {8{pos[8] ^ pos[0]}};    // Alternating bytes
         3'd5:    ram_din = {8{pos[7]}};             // Runs of 128
         default: ram_din = 8'hFF;
      endcase
   end

endmodule

`default_nettype wire

// File: logic/config_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module config_sequencer (
   input  wire                      clk,
   input  wire                      reset,
   input  wire                      load,
   input  wire msx_pkg::ram_addr_t  image_size,
   input  wire msx_pkg::byte_t      ddr3_dout,
   input  wire                      ddr3_ready,
   input  wire                      sdram_ready,
   output logic                     reset_rq,
   output msx_pkg::ddr3_addr_t      ddr3_addr,
   output logic                     ddr3_rd,
   output logic                     ddr3_request,
   output msx_pkg::ram_addr_t       ram_addr,
   output logic                     ram_ce,
   output msx_pkg::pattern_t        pattern,
   output msx_pkg::ram_addr_t       region_base,
   output logic                     clear_en,
   output msx_pkg::block_idx_t      clear_idx,
   output logic                     store_en,
   output msx_pkg::slot_sub_t       store_slot,
   output msx_pkg::byte_t           mode,
   output msx_pkg::byte_t           param,
   output msx_pkg::mapper_typ_t     mapper,
   output msx_pkg::device_typ_t     device,
   output msx_pkg::data_id_t        data_id,
   output msx_pkg::ref_ram_t        ref_ram,
   output msx_pkg::ram_addr_t       lookup_addr [msx_pkg::LOOKUP_ENTRIES],
   output msx_pkg::lookup_size_t    lookup_size [msx_pkg::LOOKUP_ENTRIES],
   output logic                     lookup_ro   [msx_pkg::LOOKUP_ENTRIES],
   output msx_pkg::byte_t           ram_size,
   output logic                     use_fdc,
   output logic               [3:0] slot_expander_en,
   output msx_pkg::msx_typ_t        msx_typ
);

   msx_pkg::state_t     state;
   msx_pkg::byte_t      conf [msx_pkg::CONF_LEN];
   logic          [3:0] conf_idx;
   msx_pkg::data_size_t data_size;
   logic                ref_add;           // Region written for this record

   wire advance = ddr3_ready & ~ddr3_rd;

   assign reset_rq    = !(state == msx_pkg::STATE_IDLE || state == msx_pkg::STATE_ERROR);
   assign clear_en    = advance && state == msx_pkg::STATE_CLEAN;
   assign store_en    = advance && state == msx_pkg::STATE_STORE_SLOT_CONFIG;
   assign region_base = lookup_addr[ref_ram];

   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= msx_pkg::STATE_IDLE;
         ddr3_rd      <= 1'b0;
         ddr3_request <= 1'b0;
         ram_ce       <= 1'b0;
      end else begin
         if (ram_ce) begin
            ram_ce   <= 1'b0;
            ram_addr <= ram_addr + 1'd1;
         end
         if (ddr3_ready && ddr3_rd) begin
            ddr3_rd   <= 1'b0;
            ddr3_addr <= ddr3_addr + 1'd1;
         end
         if (load) begin
            state     <= msx_pkg::STATE_CLEAN;
            ddr3_rd   <= 1'b0;
            ddr3_addr <= '0;
            ram_addr  <= '0;
            clear_idx <= '0;
            conf_idx  <= '0;
            ref_ram   <= '0;
            ref_add   <= 1'b0;
            ram_size  <= '0;
            use_fdc   <= 1'b0;
         end else if (advance) begin
            case (state)
               msx_pkg::STATE_CLEAN: begin
                  ddr3_request <= 1'b1;
                  clear_idx    <= clear_idx + 1'd1;
                  if (clear_idx == msx_pkg::block_idx_t'(msx_pkg::SLOT_ENTRIES - 1))
                     state <= msx_pkg::STATE_READ_CONF;
               end
               msx_pkg::STATE_READ_CONF: begin
                  conf_idx <= '0;
                  if (ddr3_addr >= msx_pkg::ddr3_addr_t'(image_size)) begin
                     state <= msx_pkg::STATE_IDLE;   // End of image
                  end else begin
                     ddr3_rd <= 1'b1;
                     state   <= msx_pkg::STATE_READ_CONF2;
                  end
               end
               msx_pkg::STATE_READ_CONF2: begin
                  conf[conf_idx] <= ddr3_dout;
                  conf_idx       <= conf_idx + 1'd1;
                  if (conf_idx == 4'(msx_pkg::CONF_LEN - 1))
                     state <= msx_pkg::STATE_CHECK_CONFIG;
                  else
                     ddr3_rd <= 1'b1;
               end
               msx_pkg::STATE_CHECK_CONFIG: begin
                  data_size <= '0;
                  if ({conf[0], conf[1], conf[2]} != {"M", "S", "X"}) begin
                     state <= msx_pkg::STATE_ERROR;
                  end else begin
                     case (msx_pkg::config_typ_t'(conf[3][7:4]))
                        msx_pkg::CONFIG_CONFIG: begin
                           slot_expander_en <= conf[4][3:0];
                           msx_typ          <= msx_pkg::msx_typ_t'(conf[4][5:4]);
                           state            <= msx_pkg::STATE_READ_CONF;
                        end
                        msx_pkg::CONFIG_SLOT_INTERNAL: begin
                           store_slot <= conf[3][3:0];
                           data_id    <= msx_pkg::data_id_t'(conf[4]);
                           data_size  <= msx_pkg::data_size_t'({conf[5][2:0], conf[6]})
                                         << msx_pkg::BLOCK_BYTES_SHIFT;
                           device     <= msx_pkg::device_typ_t'(conf[7]);
                           mapper     <= msx_pkg::mapper_typ_t'(conf[8]);
                           mode       <= conf[9];
                           param      <= conf[10];
                           pattern    <= conf[11][2:0];
                           if (msx_pkg::device_typ_t'(conf[7]) == msx_pkg::DEVICE_FDC)
                              use_fdc <= 1'b1;
                           if (msx_pkg::data_id_t'(conf[4]) == msx_pkg::ROM_RAM &&
                               ram_size < conf[6])
                              ram_size <= conf[6];
                           state      <= msx_pkg::STATE_FILL_RAM;
                        end
                        default: state <= msx_pkg::STATE_READ_CONF;
                     endcase
                  end
               end
               msx_pkg::STATE_FILL_RAM: begin
                  if (!ram_ce) begin
                     if (data_size != '0) begin
                        ref_add              <= 1'b1;
                        lookup_addr[ref_ram] <= ram_addr;
                        lookup_size[ref_ram] <= msx_pkg::lookup_size_t'(
                                                data_size >> msx_pkg::BLOCK_BYTES_SHIFT);
                        lookup_ro[ref_ram]   <= data_id != msx_pkg::ROM_RAM;
                        if (data_id == msx_pkg::ROM_ROM) begin
                           pattern <= '0;            // Copy from DDR3
                           ddr3_rd <= 1'b1;          // Prefetch first byte
                        end
                        state <= msx_pkg::STATE_FILL_RAM2;
                     end else begin
                        state <= msx_pkg::STATE_STORE_SLOT_CONFIG;
                     end
                  end
               end
               msx_pkg::STATE_FILL_RAM2: begin
                  if (sdram_ready && !ram_ce) begin
                     data_size <= data_size - 1'd1;
                     ram_ce    <= 1'b1;
                     if (data_size == 25'd1)
                        state <= msx_pkg::STATE_FILL_RAM;
                     else if (data_id == msx_pkg::ROM_ROM)
                        ddr3_rd <= 1'b1;
                  end
               end
               msx_pkg::STATE_STORE_SLOT_CONFIG: begin
                  ref_ram <= ref_ram + msx_pkg::ref_ram_t'(ref_add);
                  ref_add <= 1'b0;
                  state   <= msx_pkg::STATE_READ_CONF;
               end
               default: ddr3_request <= 1'b0;   // Idle and error
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/upload_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module upload_tracker (
   input  wire                clk,
   input  wire                reset,
   input  wire                ioctl_download,
   input  wire         [15:0] ioctl_index,
   input  wire msx_pkg::ram_addr_t ioctl_addr,
   input  wire                reload,
   output logic               load,
   output msx_pkg::ram_addr_t image_size
);

   logic download_last;

   always_ff @(posedge clk) begin
      if (reset) begin
         download_last <= 1'b0;
         load          <= 1'b0;
         image_size    <= '0;
      end else begin
         download_last <= ioctl_download;
         load          <= reload;            // Reload reuses the last size
         if (download_last && !ioctl_download && ioctl_index == msx_pkg::UPLOAD_INDEX) begin
            image_size <= ioctl_addr;        // Final address is the byte count
            load       <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/msx_pkg.sv
`default_nettype none

package msx_pkg;

   localparam int CONF_LEN          = 16;  // Bytes per record
   localparam int BLOCK_BYTES_SHIFT = 14;  // Size unit is 16 KB
   localparam int SLOT_ENTRIES      = 64;  // 4 slots x 4 subslots x 4 blocks
   localparam int LOOKUP_ENTRIES    = 16;
   localparam logic [15:0] UPLOAD_INDEX = 16'd1;

   typedef logic  [7:0] byte_t;
   typedef logic [27:0] ddr3_addr_t;
   typedef logic [26:0] ram_addr_t;
   typedef logic [24:0] data_size_t;
   typedef logic  [5:0] block_idx_t;      // {slot, subslot, block}
   typedef logic  [3:0] slot_sub_t;       // {slot, subslot}
   typedef logic  [3:0] ref_ram_t;
   typedef logic [15:0] lookup_size_t;    // In 16 KB units
   typedef logic  [2:0] pattern_t;

   typedef enum logic [3:0] {
      CONFIG_NONE,
      CONFIG_SLOT_A,                      // Cartridge records, skipped
      CONFIG_SLOT_B,
      CONFIG_SLOT_INTERNAL,
      CONFIG_KBD_LAYOUT,                  // Skipped
      CONFIG_CONFIG
   } config_typ_t;

   typedef enum logic [7:0] {
      ROM_NONE,
      ROM_ROM,
      ROM_RAM
   } data_id_t;

   typedef enum logic [7:0] {
      MAPPER_UNUSED,
      MAPPER_NONE,
      MAPPER_ASCII8,
      MAPPER_ASCII16,
      MAPPER_KONAMI,
      MAPPER_KONAMI_SCC,
      MAPPER_RAM
   } mapper_typ_t;

   typedef enum logic [7:0] {
      DEVICE_NONE,
      DEVICE_FDC
   } device_typ_t;

   typedef enum logic [1:0] {
      MSX1,
      MSX2,
      MSX2P
   } msx_typ_t;

   typedef enum logic [3:0] {
      STATE_IDLE,
      STATE_CLEAN,
      STATE_READ_CONF,
      STATE_READ_CONF2,
      STATE_CHECK_CONFIG,
      STATE_FILL_RAM,
      STATE_FILL_RAM2,
      STATE_STORE_SLOT_CONFIG,
      STATE_ERROR
   } state_t;

endpackage

`default_nettype wire
